/* Bender.yml */
package:
  name: occupancy_picker

sources:
  - include_dirs:
      - hw
    files:
      - hw/picker_pkg.sv
      - hw/parallel_counter.sv
      - hw/pick_decode.sv
      - hw/pick_execute.sv
      - hw/pick_result.sv
      - hw/occupancy_picker.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/picker_tb.sv

/* hw/occupancy_picker.sv */
`timescale 1ns/10ps

module occupancy_picker import picker_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      in_valid,
    input  pick_req_t in_req,
    output logic      out_valid,
    output pick_res_t out_res
);

    logic       dec_valid;
    dec_stage_t dec;
    logic       exe_valid;
    exe_stage_t exe;

    // stage 1: mask and keys
    pick_decode i_pick_decode (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .dec_valid (dec_valid),
        .dec       (dec)
    );

    // stage 2: minimum search and request count
    pick_execute i_pick_execute (
        .clk       (clk),
        .reset     (reset),
        .dec_valid (dec_valid),
        .dec       (dec),
        .exe_valid (exe_valid),
        .exe       (exe)
    );

    pick_result i_pick_result (
        .clk       (clk),
        .reset     (reset),
        .exe_valid (exe_valid),
        .exe       (exe),
        .out_valid (out_valid),
        .out_res   (out_res)
    );

endmodule

/* hw/parallel_counter.sv */
`timescale 1ns/10ps

// carry-sum generator: 7 inputs -> sum bit plus three weight-2 carries
module cs_gen (
    input  logic [6:0] in,
    output logic [2:0] abc,
    output logic       s
);

    logic [3:0] in1;
    logic [2:0] in2;
    logic [2:0] j1;   // ones in the low group
    logic [1:0] j2;   // ones in the high group
    logic       a;
    logic       b;
    logic       c;

    assign {in2, in1} = in;

    assign j1 = {2'b00, in1[0]} + {2'b00, in1[1]} + {2'b00, in1[2]} + {2'b00, in1[3]};
    assign j2 = {1'b0, in2[0]} + {1'b0, in2[1]} + {1'b0, in2[2]};

    assign s = j1[0] ^ j2[0];              // parity of all seven
    assign a = (j1 > 3'd1);
    assign b = (j2 > 2'd1);
    assign c = (j1 == 3'd4) | (j1[0] & j2[0]);  // leftover pair across groups

    assign abc = {a, b, c};

endmodule

// (7,3) counter
module pc_7_3 (
    input  logic [6:0] in,
    output logic [2:0] out
);

    logic [2:0] abc;

    cs_gen i_cs (
        .in  (in),
        .abc (abc),
        .s   (out[0])
    );

    // carries all carry weight 2
    assign out[2:1] = {1'b0, abc[2]} + {1'b0, abc[1]} + {1'b0, abc[0]};

endmodule

// (15,4) counter
module pc_15_4 (
    input  logic [14:0] in,
    output logic [3:0]  out
);

    logic [2:0] abc0;
    logic [2:0] abc1;
    logic       s0;
    logic       s1;
    logic       b2;

    cs_gen i_cs0 (
        .in  (in[6:0]),
        .abc (abc0),
        .s   (s0)
    );

    cs_gen i_cs1 (
        .in  (in[13:7]),
        .abc (abc1),
        .s   (s1)
    );

    // spare input folds in with both sum bits
    assign {b2, out[0]} = {1'b0, in[14]} + {1'b0, s0} + {1'b0, s1};

    pc_7_3 i_pc_sub (
        .in  ({abc0, abc1, b2}),
        .out (out[3:1])
    );

endmodule

/* hw/pick_decode.sv */
`timescale 1ns/10ps
`include "picker_settings.svh"

module pick_decode import picker_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       in_valid,
    input  pick_req_t  in_req,
    output logic       dec_valid,
    output dec_stage_t dec
);

    localparam int PORTS = `PICK_PORTS;
    localparam int IDX_W = `PICK_IDX_W;

    logic [PORTS-1:0] idx_onehot;
    logic [PORTS-1:0] req_mask;
    dec_stage_t       dec_next;

    // index view to one-hot, upper payload bits ignored
    for (genvar i = 0; i < PORTS; i++) begin : g_onehot
        assign idx_onehot[i] = (in_req.cmd.payload.idx.port == IDX_W'(i));
    end

    assign req_mask = in_req.cmd.mode ? idx_onehot : in_req.cmd.payload.mask;

    always_comb begin
        dec_next.mask = req_mask;
        dec_next.occ  = in_req.occ;
        for (int i = 0; i < PORTS; i++) begin
            dec_next.key[i].unreq = ~req_mask[i];  // pushes idle ports past 31
            dec_next.key[i].occ   = in_req.occ[i];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= in_valid;
        end
    end

    // payload only loads on a valid request
    always_ff @(posedge clk) begin
        if (in_valid) begin
            dec <= dec_next;
        end
    end

endmodule

/* hw/pick_execute.sv */
`timescale 1ns/10ps
`include "picker_settings.svh"

module pick_execute import picker_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       dec_valid,
    input  dec_stage_t dec,
    output logic       exe_valid,
    output exe_stage_t exe
);

    localparam int PORTS = `PICK_PORTS;
    localparam int CNT_W = `PICK_CNT_W;
    localparam int PC_W  = 15;

    // cmp[i][j]: port i beats port j
    logic [PORTS-1:0] cmp [PORTS];
    logic [PORTS-1:0] winner;
    logic [PC_W-1:0]  cnt_in;
    logic [CNT_W-1:0] count;

    // pairwise comparators, lower half reuses the upper half inverted
    for (genvar i = 0; i < PORTS; i++) begin : g_row
        for (genvar j = 0; j < PORTS; j++) begin : g_col
            if (j > i) begin : g_upper
                assign cmp[i][j] = (dec.key[i] <= dec.key[j]);  // tie goes to i
            end else if (j < i) begin : g_lower
                assign cmp[i][j] = ~cmp[j][i];                  // strict less
            end else begin : g_diag
                assign cmp[i][j] = 1'b1;
            end
        end
        assign winner[i] = &cmp[i];
    end

    assign cnt_in = {{(PC_W-PORTS){1'b0}}, dec.mask};

    pc_15_4 i_pc_15_4 (
        .in  (cnt_in),
        .out (count)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            exe_valid <= 1'b0;
        end else begin
            exe_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            exe.winner <= winner;
            exe.count  <= count;
            exe.occ    <= dec.occ;
        end
    end

    // network must pick exactly one port, even for an empty mask
    a_winner_onehot: assert property (
        @(posedge clk) disable iff (reset)
        exe_valid |-> $onehot(exe.winner)
    );

endmodule

/* hw/pick_result.sv */
`timescale 1ns/10ps
`include "picker_settings.svh"

module pick_result import picker_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       exe_valid,
    input  exe_stage_t exe,
    output logic       out_valid,
    output pick_res_t  out_res
);

    localparam int PORTS = `PICK_PORTS;
    localparam int IDX_W = `PICK_IDX_W;
    localparam int OCC_W = `PICK_OCC_W;
    localparam int SEL_W = IDX_W + OCC_W;

    logic [SEL_W-1:0] sel_word;   // {port, occ} of the winner
    pick_res_t        res_next;

    // one-hot mux, each entry is the constant index next to its occupancy
    always_comb begin
        sel_word = '0;
        for (int i = 0; i < PORTS; i++) begin
            sel_word |= {SEL_W{exe.winner[i]}} & {IDX_W'(i), exe.occ[i]};
        end
    end

    always_comb begin
        {res_next.port, res_next.occ} = sel_word;
        res_next.count                = exe.count;
        res_next.none                 = (exe.count == '0);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= exe_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (exe_valid) begin
            out_res <= res_next;
        end
    end

    a_none_vs_count: assert property (
        @(posedge clk) disable iff (reset)
        (out_valid && out_res.count != '0) |-> !out_res.none
    );

endmodule

/* hw/picker_pkg.sv */
`include "picker_settings.svh"

package picker_pkg;

    typedef logic [`PICK_OCC_W-1:0] pick_occ_t;

    // index view of the command payload, low bits name one port
    typedef struct packed {
        logic [`PICK_PORTS-`PICK_IDX_W-1:0] unused;
        logic [`PICK_IDX_W-1:0]             port;
    } pick_idx_view_t;

    typedef union packed {
        logic [`PICK_PORTS-1:0] mask;   // one request bit per port
        pick_idx_view_t         idx;
    } pick_cmd_u;

    typedef struct packed {
        logic      mode;      // 1 = index view
        pick_cmd_u payload;
    } pick_cmd_t;

    typedef struct packed {
        pick_cmd_t                   cmd;
        pick_occ_t [`PICK_PORTS-1:0] occ;
    } pick_req_t;

    // unrequested ports sort above every requested one
    typedef struct packed {
        logic      unreq;
        pick_occ_t occ;
    } pick_key_t;

    typedef struct packed {
        logic      [`PICK_PORTS-1:0] mask;
        pick_key_t [`PICK_PORTS-1:0] key;
        pick_occ_t [`PICK_PORTS-1:0] occ;
    } dec_stage_t;

    typedef struct packed {
        logic      [`PICK_PORTS-1:0] winner;  // one-hot
        logic      [`PICK_CNT_W-1:0] count;
        pick_occ_t [`PICK_PORTS-1:0] occ;
    } exe_stage_t;

    typedef struct packed {
        logic [`PICK_IDX_W-1:0] port;
        pick_occ_t              occ;
        logic [`PICK_CNT_W-1:0] count;
        logic                   none;
    } pick_res_t;

endpackage

/* hw/picker_settings.svh */
`ifndef PICKER_SETTINGS_SVH
`define PICKER_SETTINGS_SVH

// number of output ports seen by the allocator
`define PICK_PORTS 8

// buffer occupancy per port
`define PICK_OCC_W 5

// binary port index, log2 of PICK_PORTS
`define PICK_IDX_W 3

// request count width, output of the 15-input counter
`define PICK_CNT_W 4

`endif

/* occupancy_picker.f */
+incdir+hw
hw/picker_pkg.sv
hw/parallel_counter.sv
hw/pick_decode.sv
hw/pick_execute.sv
hw/pick_result.sv
hw/occupancy_picker.sv
verif/picker_tb.sv

/* verif/picker_tb.sv */
`timescale 1ns/10ps
`include "picker_settings.svh"

module picker_tb import picker_pkg::*; ();

    localparam int IDLE_AT       = 8;    // idle gap before this vector
    localparam int DRAIN_TIMEOUT = 50;

    logic      clk;
    logic      reset;
    logic      in_valid;
    pick_req_t in_req;
    logic      out_valid;
    pick_res_t out_res;

    int        cyc = 0;
    int        n_res = 0;
    pick_req_t req_q [$];
    pick_res_t exp_q [$];
    string     name_q [$];
    int        sampled_cyc [$];  // edge where the DUT took each request

    occupancy_picker i_occupancy_picker (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_res   (out_res)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_value(string test, string field, logic [31:0] expected,
                               logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error: %s %s expected %0d actual %0d", test, field, expected, actual);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    task automatic load_tests();
        int         fd;
        int         n;
        string      line;
        string      name;
        int         mode;
        logic [7:0] payload;
        int         occ [8];
        int         exp_val [4];   // port, occ, count, none
        pick_req_t  req;
        pick_res_t  res;
        fd = $fopen("verif/picker_tests.txt", "r");
        if (fd == 0) abort_run("cannot open verif/picker_tests.txt");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") continue;  // comments and blank lines
            n = $sscanf(line, "%s %d %h %d %d %d %d %d %d %d %d %d %d %d %d",
                        name, mode, payload, occ[0], occ[1], occ[2], occ[3],
                        occ[4], occ[5], occ[6], occ[7],
                        exp_val[0], exp_val[1], exp_val[2], exp_val[3]);
            if (n != 15) abort_run("malformed line in verif/picker_tests.txt");
            req.cmd.mode         = mode[0];
            req.cmd.payload.mask = payload;
            for (int i = 0; i < `PICK_PORTS; i++) begin
                req.occ[i] = `PICK_OCC_W'(occ[i]);
            end
            res.port  = `PICK_IDX_W'(exp_val[0]);
            res.occ   = `PICK_OCC_W'(exp_val[1]);
            res.count = `PICK_CNT_W'(exp_val[2]);
            res.none  = exp_val[3][0];
            req_q.push_back(req);
            exp_q.push_back(res);
            name_q.push_back(name);
        end
        $fclose(fd);
        if (req_q.size() == 0) abort_run("no test vectors found");
    endtask

    task automatic check_result(int idx);
        pick_res_t exp;
        exp = exp_q[idx];
        check_value(name_q[idx], "latency", 3, cyc - sampled_cyc[idx]);
        check_value(name_q[idx], "count", exp.count, out_res.count);
        check_value(name_q[idx], "none", exp.none, out_res.none);
        if (!exp.none) begin  // winner is undefined for an empty mask
            check_value(name_q[idx], "port", exp.port, out_res.port);
            check_value(name_q[idx], "occ", exp.occ, out_res.occ);
        end
    endtask

    // results come back in request order
    always @(posedge clk) begin
        if (cyc > 0 && out_valid !== 1'b0) begin
            if (out_valid !== 1'b1) begin
                abort_run("out_valid is unknown");
            end else begin
                if (n_res < sampled_cyc.size()) begin
                    check_result(n_res);
                end
                n_res = n_res + 1;
            end
        end
    end

    initial begin
        int wait_cycles;
        reset    = 1'b1;
        in_valid = 1'b0;
        in_req   = '0;
        load_tests();
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < req_q.size(); i++) begin
            if (i == IDLE_AT) begin
                @(posedge clk);
                in_valid <= 1'b0;
                repeat (4) @(posedge clk);
            end
            @(posedge clk);
            in_valid <= 1'b1;
            in_req   <= req_q[i];
            sampled_cyc.push_back(cyc + 1);
        end
        @(posedge clk);
        in_valid <= 1'b0;
        wait_cycles = 0;
        while (n_res < req_q.size()) begin
            @(negedge clk);
            wait_cycles++;
            if (wait_cycles > DRAIN_TIMEOUT) abort_run("timeout waiting for results");
        end
        repeat (5) @(negedge clk);  // catch stray out_valid after the last result
        if (n_res == req_q.size()) begin
            $display("TEST PASS");
        end else begin
            check_value("end of run", "result count", req_q.size(), n_res);
        end
        $finish;
    end

endmodule

/* verif/picker_tests.txt */
# name mode payload(hex) occ0..occ7 | expected port occ count none
# port and occ are ignored when none is 1
mask_mixed          0 b5 12  7  3  9 20 14  1  6   2  3 5 0
mask_two            0 42  0 18  5  5  5  5 17  5   6 17 2 0
mask_single_top     0 80  1  1  1  1  1  1  1 31   7 31 1 0
tie_low_wins        0 3c  9  9  8  4  4 10  4  4   3  4 4 0
tie_unreq_smaller   0 a0  0  0  0  0  0  6  2  6   5  6 2 0
tie_max31           0 19 31  0  0 31 31  0  0  0   0 31 3 0
tie_max31_high      0 c0  0  0  0  0  0  0 31 31   6 31 2 0
mask_low_ports      0 0f 16  2  2  0  1  1  1  1   3  0 4 0
index_port5         1 05  0  1  2  3  4 30  6  7   5 30 1 0
index_unused_bits   1 fa  3  3 31  3  3  3  3  3   2 31 1 0
index_port0         1 08 25  0  0  0  0  0  0  0   0 25 1 0
index_port7         1 67  0  0  0  0  0  0  0 13   7 13 1 0
empty_mask          0 00  4  8 15 16 23 42 29 30   0  0 0 1
full_mask           0 ff 17 22  9 30  9 11 15 28   2  9 8 0
full_all_equal      0 ff  7  7  7  7  7  7  7  7   0  7 8 0
empty_mask_again    0 00  0  0  0  0  0  0  0  0   0  0 0 1
